/* design/cmd_fifo.sv */
`timescale 1ns/1ns
`include "dwc_defs.svh"

module cmd_fifo (
  input  logic              clk,
  input  logic              rst,
  input  dwc_pkg::pre_cmd_t wr_data,
  input  logic              wr_valid,
  output logic              wr_ready,
  output dwc_pkg::pre_cmd_t rd_data,
  output logic              rd_valid,
  input  logic              rd_ready
);

  localparam int DEPTH = `DWC_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  dwc_pkg::pre_cmd_t mem [DEPTH];

  // msb is the wrap bit
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;
  logic           full;
  logic           empty;

  // same slot, different lap
  assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  assign wr_ready = !full;
  assign rd_valid = !empty;
  // head entry, shown combinationally
  assign rd_data  = mem[rd_ptr[PTR_W-1:0]];

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (wr_valid && !full)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ready && !empty)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk)
  begin
    if (wr_valid && !full)
    begin
      mem[wr_ptr[PTR_W-1:0]] <= wr_data;
    end
  end

endmodule

/* design/down_conv_cmd_split.sv */
`timescale 1ns/1ns

module down_conv_cmd_split (
  input  logic               clk,
  input  logic               rst,
  input  dwc_pkg::pre_cmd_t  q_cmd,
  input  logic               q_valid,
  output logic               q_ready,
  output dwc_pkg::addr_cmd_t s_cmd,
  output logic               s_valid,
  input  logic               s_ready
);

  // longest incr burst
  localparam dwc_pkg::beat_cnt_t MAX_CHUNK = 13'd256;

  dwc_pkg::split_state_e state;
  dwc_pkg::pre_cmd_t     held;
  // beats left for incr, bursts left otherwise
  dwc_pkg::beat_cnt_t    rem;
  dwc_pkg::beat_cnt_t    rem_init;
  dwc_pkg::beat_cnt_t    chunk;
  dwc_pkg::addr_t        cur_addr;
  logic                  incr_mode;
  logic                  last;

  assign q_ready = (state == dwc_pkg::IDLE);
  assign s_valid = (state == dwc_pkg::ISSUE);

  // one counter, meaning depends on mode
  always_comb
  begin
    if (q_cmd.same_size)
    begin
      rem_init = 13'd1;
    end
    else if (q_cmd.cmd.burst == dwc_pkg::FIXED)
    begin
      rem_init = dwc_pkg::beat_cnt_t'(q_cmd.cmd.len) + 13'd1;
    end
    else
    begin
      rem_init = q_cmd.tot_len;
    end
  end

  // wrap is split like incr
  assign incr_mode = !held.same_size && (held.cmd.burst != dwc_pkg::FIXED);

  // size of this step
  assign chunk = !incr_mode ? 13'd1 : ((rem > MAX_CHUNK) ? MAX_CHUNK : rem);
  assign last  = (rem == chunk);

  ////////////////////
  // slave command
  ////////////////////

  always_comb
  begin
    s_cmd      = held.cmd;
    s_cmd.size = held.slv_size;
    s_cmd.addr = cur_addr;
    if (!held.same_size)
    begin
      s_cmd.burst = dwc_pkg::INCR;
      // fixed master beat becomes a short incr
      if (incr_mode)
      begin
        s_cmd.len = dwc_pkg::axi_len_t'(chunk - 13'd1);
      end
      else
      begin
        s_cmd.len = dwc_pkg::axi_len_t'(held.fixed_beats - 9'd1);
      end
    end
  end

  ////////////////////
  // fsm
  ////////////////////

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      state <= dwc_pkg::IDLE;
    end
    else
    begin
      case (state)
        dwc_pkg::IDLE:
        begin
          // entry popped here
          if (q_valid)
          begin
            state <= dwc_pkg::ISSUE;
          end
        end
        dwc_pkg::ISSUE:
        begin
          if (s_ready)
          begin
            state <= last ? dwc_pkg::IDLE : dwc_pkg::NEXT;
          end
        end
        dwc_pkg::NEXT:
        begin
          state <= dwc_pkg::ISSUE;
        end
        default:
        begin
          state <= dwc_pkg::IDLE;
        end
      endcase
    end
  end

  // counters and held entry
  always_ff @(posedge clk)
  begin
    if (state == dwc_pkg::IDLE && q_valid)
    begin
      held     <= q_cmd;
      rem      <= rem_init;
      cur_addr <= q_cmd.aligned_addr;
    end
    else if (state == dwc_pkg::NEXT)
    begin
      rem <= rem - chunk;
      // fixed bursts stay put
      if (incr_mode)
      begin
        cur_addr <= cur_addr + (dwc_pkg::addr_t'(chunk) << held.slv_size);
      end
    end
  end

endmodule

/* design/down_conv_pre_calc.sv */
`timescale 1ns/1ns
`include "dwc_defs.svh"

module down_conv_pre_calc (
  input  logic                clk,
  input  logic                rst,
  input  dwc_pkg::addr_cmd_t  m_cmd,
  input  logic                m_valid,
  output logic                m_ready,
  output dwc_pkg::pre_cmd_t   pre_cmd,
  output logic                pre_valid,
  input  logic                pre_ready
);

  // log2 of slave bus bytes
  localparam int unsigned SLV_MAX = $clog2(`DWC_DATA_OUT_W / 8);

  logic                load;
  dwc_pkg::axi_size_t  slv_size_c;
  dwc_pkg::axi_size_t  size_diff_c;
  logic [5:0]          mst_lo_mask;
  logic [5:0]          len_offset_c;
  dwc_pkg::beat_cnt_t  tot_aligned;
  dwc_pkg::addr_t      slv_lo_mask;
  dwc_pkg::pre_cmd_t   pre_next;

  ////////////////////
  // size reduction
  ////////////////////

  // clamp to slave width
  assign slv_size_c  = (m_cmd.size > SLV_MAX) ? dwc_pkg::axi_size_t'(SLV_MAX) : m_cmd.size;
  assign size_diff_c = m_cmd.size - slv_size_c;

  // byte lanes below master size
  assign mst_lo_mask = ~(6'h3f << m_cmd.size);
  // start offset inside master beat, in slave beats
  assign len_offset_c = (m_cmd.addr[5:0] & mst_lo_mask) >> slv_size_c;

  // master beats expanded to slave beats
  assign tot_aligned = (dwc_pkg::beat_cnt_t'(m_cmd.len) + 13'd1) << size_diff_c;

  // byte lanes below slave size
  assign slv_lo_mask = (dwc_pkg::addr_t'(1) << slv_size_c) - dwc_pkg::addr_t'(1);

  ////////////////////
  // next register value
  ////////////////////

  always_comb
  begin
    pre_next            = '0;
    pre_next.cmd        = m_cmd;
    pre_next.slv_size   = slv_size_c;
    pre_next.size_diff  = size_diff_c;
    pre_next.same_size  = (size_diff_c == 3'd0);
    pre_next.len_offset = len_offset_c;

    // incr loses the skipped leading slave beats
    if (m_cmd.burst == dwc_pkg::FIXED)
    begin
      pre_next.tot_len = tot_aligned;
    end
    else
    begin
      pre_next.tot_len = tot_aligned - {7'b0, len_offset_c};
    end

    // slave beats for one fixed master beat
    pre_next.fixed_beats = (9'd1 << size_diff_c) - {3'b0, len_offset_c};

    // fixed bursts restart at slave-aligned address
    if (m_cmd.burst == dwc_pkg::FIXED && size_diff_c != 3'd0)
    begin
      pre_next.aligned_addr = m_cmd.addr & ~slv_lo_mask;
    end
    else
    begin
      pre_next.aligned_addr = m_cmd.addr;
    end

    // log2 of wrap length
    case (m_cmd.len)
      8'h0f:   pre_next.wrap_log_len = 3'd4;
      8'h07:   pre_next.wrap_log_len = 3'd3;
      8'h03:   pre_next.wrap_log_len = 3'd2;
      default: pre_next.wrap_log_len = 3'd1;
    endcase
  end

  // payload only, valid lives in the controller
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      pre_cmd <= pre_next;
    end
  end

  hold_reg_ctrl u_hold_ctrl (
    .clk        (clk),
    .rst        (rst),
    .src_valid  (m_valid),
    .dst_ready  (pre_ready),
    .load       (load),
    .src_ready  (m_ready),
    .hold_valid (pre_valid)
  );

endmodule

/* design/dwc_defs.svh */
`ifndef DWC_DEFS_SVH
`define DWC_DEFS_SVH

////////////////////
// bus widths
////////////////////

// master and slave share these
`define DWC_ADDR_W 32
`define DWC_ID_W 4
`define DWC_USER_W 4

// slave data bus, 4 bytes per beat so max slave size is 2
`define DWC_DATA_OUT_W 32

////////////////////
// buffering
////////////////////

// entries in the pre-calculated command queue
`define DWC_FIFO_DEPTH 4

`endif

/* design/dwc_pkg.sv */
`include "dwc_defs.svh"

package dwc_pkg;

  // widths with a meaning of their own
  typedef logic [`DWC_ADDR_W-1:0] addr_t;
  typedef logic [7:0]             axi_len_t;
  typedef logic [2:0]             axi_size_t;
  // total slave beats of one master command
  typedef logic [12:0]            beat_cnt_t;

  // axi burst encoding
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  // splitter fsm
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    NEXT
  } split_state_e;

  ////////////////////
  // command structs
  ////////////////////

  // one aw command, master or slave side
  typedef struct packed {
    logic [`DWC_ID_W-1:0]   id;
    addr_t                  addr;
    axi_len_t               len;
    axi_size_t              size;
    burst_e                 burst;
    logic [3:0]             cache;
    logic [1:0]             lock;
    logic [2:0]             prot;
    logic [3:0]             qos;
    logic [3:0]             region;
    logic [`DWC_USER_W-1:0] user;
  } addr_cmd_t;

  // master command plus precomputed split info
  typedef struct packed {
    addr_cmd_t  cmd;
    axi_size_t  slv_size;
    axi_size_t  size_diff;
    logic       same_size;
    logic [5:0] len_offset;
    beat_cnt_t  tot_len;
    logic [8:0] fixed_beats;
    addr_t      aligned_addr;
    logic [2:0] wrap_log_len;
  } pre_cmd_t;

endpackage

/* design/dwc_wr_cmd_top.sv */
`timescale 1ns/1ns

module dwc_wr_cmd_top (
  input  logic               clk,
  input  logic               rst,
  input  dwc_pkg::addr_cmd_t m_cmd,
  input  logic               m_valid,
  output logic               m_ready,
  output dwc_pkg::addr_cmd_t s_cmd,
  output logic               s_valid,
  input  logic               s_ready
);

  // pre-calc to fifo
  dwc_pkg::pre_cmd_t pre_cmd;
  logic              pre_valid;
  logic              pre_ready;

  // fifo to splitter
  dwc_pkg::pre_cmd_t q_cmd;
  logic              q_valid;
  logic              q_ready;

  down_conv_pre_calc u_pre_calc (
    .clk       (clk),
    .rst       (rst),
    .m_cmd     (m_cmd),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .pre_cmd   (pre_cmd),
    .pre_valid (pre_valid),
    .pre_ready (pre_ready)
  );

  cmd_fifo u_cmd_fifo (
    .clk      (clk),
    .rst      (rst),
    .wr_data  (pre_cmd),
    .wr_valid (pre_valid),
    .wr_ready (pre_ready),
    .rd_data  (q_cmd),
    .rd_valid (q_valid),
    .rd_ready (q_ready)
  );

  down_conv_cmd_split u_cmd_split (
    .clk     (clk),
    .rst     (rst),
    .q_cmd   (q_cmd),
    .q_valid (q_valid),
    .q_ready (q_ready),
    .s_cmd   (s_cmd),
    .s_valid (s_valid),
    .s_ready (s_ready)
  );

endmodule

/* design/hold_reg_ctrl.sv */
`timescale 1ns/1ns

module hold_reg_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic src_valid,
  input  logic dst_ready,
  output logic load,
  output logic src_ready,
  output logic hold_valid
);

  // holding register occupied
  logic full;
  // low until first edge after reset
  logic run;

  // empty, or its content leaves this cycle
  assign src_ready = run && (!full || dst_ready);

  // take new data whenever there is room
  assign load = src_valid && src_ready;

  assign hold_valid = full;

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      run  <= 1'b0;
      full <= 1'b0;
    end
    else
    begin
      run <= 1'b1;
      // refill wins over drain
      if (load)
      begin
        full <= 1'b1;
      end
      else if (dst_ready)
      begin
        full <= 1'b0;
      end
    end
  end

endmodule

/* list.f */
+incdir+design
+incdir+tests
design/dwc_pkg.sv
design/hold_reg_ctrl.sv
design/down_conv_pre_calc.sv
design/cmd_fifo.sv
design/down_conv_cmd_split.sv
design/dwc_wr_cmd_top.sv
tests/dwc_tb.sv

/* run.sh */
#!/bin/sh
# build and run the write-address down-converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module dwc_tb -f list.f \
  -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/Vdwc_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

# verdict comes from the log only
if grep -q "^Result: PASSED$" "$SIM_LOG"; then
  exit 0
fi
exit 1

/* tests/dwc_tb_vectors.svh */
`ifndef DWC_TB_VECTORS_SVH
`define DWC_TB_VECTORS_SVH

// columns: id, addr, len, size, burst, back-pressure flag,
// expected slave commands, expected slave beats
typedef struct packed {
  logic [3:0]         id;
  dwc_pkg::addr_t     addr;
  dwc_pkg::axi_len_t  len;
  dwc_pkg::axi_size_t size;
  dwc_pkg::burst_e    burst;
  logic               bp;
  dwc_pkg::beat_cnt_t exp_cmds;
  dwc_pkg::beat_cnt_t exp_beats;
} vec_t;

localparam int NUM_VECS = 14;

vec_t vecs [NUM_VECS];

task automatic fill_vectors();
  // equal sizes, forwarded untouched
  vecs[0]  = '{4'h1, 32'h0000_1000, 8'd7,   3'd2, dwc_pkg::INCR,  1'b0, 13'd1, 13'd8};
  vecs[1]  = '{4'h2, 32'h0000_2002, 8'd3,   3'd1, dwc_pkg::FIXED, 1'b0, 13'd1, 13'd4};
  // incr downsizing, aligned then unaligned
  vecs[2]  = '{4'h3, 32'h0000_3000, 8'd3,   3'd3, dwc_pkg::INCR,  1'b0, 13'd1, 13'd8};
  vecs[3]  = '{4'h4, 32'h0000_3004, 8'd3,   3'd3, dwc_pkg::INCR,  1'b0, 13'd1, 13'd7};
  vecs[4]  = '{4'h5, 32'h0000_4008, 8'd1,   3'd4, dwc_pkg::INCR,  1'b0, 13'd1, 13'd6};
  // over 256 slave beats
  vecs[5]  = '{4'h6, 32'h0001_0000, 8'd255, 3'd4, dwc_pkg::INCR,  1'b0, 13'd4, 13'd1024};
  vecs[6]  = '{4'h7, 32'h0000_5004, 8'd200, 3'd3, dwc_pkg::INCR,  1'b0, 13'd2, 13'd401};
  // fixed, one short incr per master beat
  vecs[7]  = '{4'h8, 32'h0000_6006, 8'd3,   3'd3, dwc_pkg::FIXED, 1'b0, 13'd4, 13'd4};
  vecs[8]  = '{4'h9, 32'h0000_7000, 8'd1,   3'd4, dwc_pkg::FIXED, 1'b0, 13'd2, 13'd8};
  // back to back under random s_ready
  vecs[9]  = '{4'ha, 32'h0000_8000, 8'd255, 3'd4, dwc_pkg::INCR,  1'b1, 13'd4, 13'd1024};
  vecs[10] = '{4'hb, 32'h0000_9000, 8'd2,   3'd3, dwc_pkg::FIXED, 1'b1, 13'd3, 13'd6};
  vecs[11] = '{4'hc, 32'h0000_a000, 8'd15,  3'd2, dwc_pkg::INCR,  1'b1, 13'd1, 13'd16};
  vecs[12] = '{4'hd, 32'h0000_b00c, 8'd9,   3'd3, dwc_pkg::INCR,  1'b1, 13'd1, 13'd19};
  vecs[13] = '{4'he, 32'h0000_c004, 8'd0,   3'd4, dwc_pkg::INCR,  1'b1, 13'd1, 13'd3};
endtask

`endif

/* tests/dwc_tb.sv */
`timescale 1ns/1ns

module dwc_tb;

  // largest slave size, 32-bit slave bus
  localparam dwc_pkg::axi_size_t SLV_MAX_SIZE = 3'd2;
  localparam int WAIT_LIMIT = 2000;

  logic               clk = 1'b0;
  logic               rst;
  dwc_pkg::addr_cmd_t m_cmd;
  logic               m_valid;
  logic               m_ready;
  dwc_pkg::addr_cmd_t s_cmd;
  logic               s_valid;
  logic               s_ready = 1'b0;

  integer      seed = 32'h9661;
  logic [31:0] rnd;
  logic        bp_mode;

  // expected slave commands, with the row each belongs to
  dwc_pkg::addr_cmd_t exp_q [$];
  int                 exp_row [$];

  int                 errors = 0;
  int                 row_mark = 0;
  int                 rows_done = 0;
  int                 mon_row;
  dwc_pkg::addr_cmd_t mon_exp;
  // slave side tallies, by id seen on s_cmd
  dwc_pkg::beat_cnt_t id_cmds [16];
  dwc_pkg::beat_cnt_t id_beats [16];
  logic               timed_out;

  `include "dwc_tb_vectors.svh"

  dwc_wr_cmd_top UUT (
    .clk     (clk),
    .rst     (rst),
    .m_cmd   (m_cmd),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .s_cmd   (s_cmd),
    .s_valid (s_valid),
    .s_ready (s_ready)
  );

  always #2 clk = ~clk;

  // slave ready, random only under back-pressure
  always @(negedge clk)
  begin
    rnd = $random(seed);
    s_ready = bp_mode ? rnd[0] : 1'b1;
  end

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_cmd(input string name, input dwc_pkg::addr_cmd_t exp,
                           input dwc_pkg::addr_cmd_t got);
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic check_count(input string name, input dwc_pkg::beat_cnt_t exp,
                             input dwc_pkg::beat_cnt_t got);
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s exp %h got %h", name, exp, got);
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // side fields vary per row so pass-through is visible
  function automatic dwc_pkg::addr_cmd_t make_cmd(input int idx, input vec_t v);
    dwc_pkg::addr_cmd_t c;
    c.id     = v.id;
    c.addr   = v.addr;
    c.len    = v.len;
    c.size   = v.size;
    c.burst  = v.burst;
    c.cache  = 4'(idx);
    c.lock   = 2'(idx % 2);
    c.prot   = 3'(idx);
    c.qos    = 4'(15 - idx);
    c.region = 4'(idx * 3);
    c.user   = ~c.cache;
    return c;
  endfunction

  task automatic add_expected(input int row, input dwc_pkg::addr_cmd_t m,
                              output dwc_pkg::beat_cnt_t n_cmds,
                              output dwc_pkg::beat_cnt_t n_beats);
    dwc_pkg::addr_cmd_t c;
    dwc_pkg::axi_size_t slv;
    dwc_pkg::addr_t     a;
    int ratio;
    int offs;
    int left;
    int step;
    slv = (m.size > SLV_MAX_SIZE) ? SLV_MAX_SIZE : m.size;
    c = m;
    n_cmds = '0;
    n_beats = '0;
    if (slv == m.size)
    begin
      exp_q.push_back(m);
      exp_row.push_back(row);
      n_cmds = 13'd1;
      n_beats = dwc_pkg::beat_cnt_t'(int'(m.len) + 1);
      return;
    end
    // slave beats per master beat, and leading beats skipped
    ratio = 1 << int'(m.size - slv);
    offs = int'(m.addr & ((dwc_pkg::addr_t'(1) << m.size) - dwc_pkg::addr_t'(1))) >> slv;
    c.size = slv;
    c.burst = dwc_pkg::INCR;
    if (m.burst == dwc_pkg::FIXED)
    begin
      c.addr = m.addr & ~((dwc_pkg::addr_t'(1) << slv) - dwc_pkg::addr_t'(1));
      c.len = dwc_pkg::axi_len_t'(ratio - offs - 1);
      for (int i = 0; i <= int'(m.len); i++)
      begin
        exp_q.push_back(c);
        exp_row.push_back(row);
      end
      n_cmds = dwc_pkg::beat_cnt_t'(int'(m.len) + 1);
      n_beats = dwc_pkg::beat_cnt_t'((int'(m.len) + 1) * (ratio - offs));
    end
    else
    begin
      left = (int'(m.len) + 1) * ratio - offs;
      a = m.addr;
      // chunks of at most 256 beats
      while (left > 0)
      begin
        step = (left > 256) ? 256 : left;
        c.addr = a;
        c.len = dwc_pkg::axi_len_t'(step - 1);
        exp_q.push_back(c);
        exp_row.push_back(row);
        a = a + (dwc_pkg::addr_t'(step) << slv);
        left = left - step;
        n_cmds = n_cmds + 13'd1;
        n_beats = n_beats + dwc_pkg::beat_cnt_t'(step);
      end
    end
  endtask

  ////////////////////
  // run control
  ////////////////////

  task automatic end_run();
    $display("%0d of %0d rows finished, %0d errors", rows_done, NUM_VECS, errors);
    if (errors == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  task automatic finish_row(input int row);
    dwc_pkg::beat_cnt_t n_cmds;
    dwc_pkg::beat_cnt_t n_beats;
    n_cmds = id_cmds[vecs[row].id];
    n_beats = id_beats[vecs[row].id];
    check_count("s_cmd count", vecs[row].exp_cmds, n_cmds);
    check_count("s_cmd beats", vecs[row].exp_beats, n_beats);
    $display("row %0d: %0d slave cmds, %0d beats, %s", row, n_cmds, n_beats,
             (errors == row_mark) ? "ok" : "mismatch");
    rows_done++;
    row_mark = errors;
  endtask

  // master handshake, held until m_ready at a rising edge
  task automatic send_cmd(input dwc_pkg::addr_cmd_t c);
    int   waited;
    logic taken;
    m_cmd = c;
    m_valid = 1'b1;
    waited = 0;
    taken = 1'b0;
    while (!taken && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      taken = m_ready;
      waited++;
      @(negedge clk);
    end
    m_valid = 1'b0;
    if (!taken)
    begin
      $display("timed out waiting for m_ready on id %h", c.id);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      $display("timed out with %0d slave commands still missing", exp_q.size());
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // slave side monitor, handshake at the rising edge
  always @(posedge clk)
  begin
    if (rst && s_valid && s_ready)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("slave command %h arrived with none expected", s_cmd);
      end
      else
      begin
        mon_exp = exp_q.pop_front();
        mon_row = exp_row.pop_front();
        check_cmd("s_cmd", mon_exp, s_cmd);
        id_cmds[s_cmd.id] = id_cmds[s_cmd.id] + 13'd1;
        id_beats[s_cmd.id] = id_beats[s_cmd.id] + dwc_pkg::beat_cnt_t'(s_cmd.len) + 13'd1;
        if (exp_row.size() == 0 || exp_row[0] != mon_row)
        begin
          finish_row(mon_row);
        end
      end
    end
  end

  initial
  begin
    dwc_pkg::addr_cmd_t m;
    dwc_pkg::beat_cnt_t n_cmds;
    dwc_pkg::beat_cnt_t n_beats;
    m_cmd = '0;
    m_valid = 1'b0;
    bp_mode = 1'b0;
    rst = 1'b0;
    timed_out = 1'b0;
    for (int k = 0; k < 16; k++)
    begin
      id_cmds[k] = '0;
      id_beats[k] = '0;
    end
    fill_vectors();
    repeat (10) @(negedge clk);
    rst = 1'b1;
    // one edge out of reset, idle and ready
    @(negedge clk);
    check_bit("m_ready", 1'b1, m_ready);
    check_bit("s_valid", 1'b0, s_valid);
    $display("reset state: %s", (errors == 0) ? "ok" : "mismatch");
    row_mark = errors;
    for (int i = 0; i < NUM_VECS && !timed_out; i++)
    begin
      m = make_cmd(i, vecs[i]);
      add_expected(i, m, n_cmds, n_beats);
      check_count("model cmds", vecs[i].exp_cmds, n_cmds);
      check_count("model beats", vecs[i].exp_beats, n_beats);
      bp_mode = vecs[i].bp;
      send_cmd(m);
      // plain rows finish before the next one
      if (!vecs[i].bp && !timed_out)
      begin
        wait_drain();
      end
    end
    if (!timed_out)
    begin
      wait_drain();
    end
    // quiet window, catches duplicates
    if (!timed_out)
    begin
      repeat (20) @(negedge clk);
    end
    end_run();
  end

endmodule
